// File: rom_pkg.sv
/* Shared widths, region offsets and payload types of the ROM slot hub
   Referenced by scoped names from the RTL and the testbench */
package rom_pkg;

// SDRAM side
localparam int SDRAM_AW = 22;       // Word address
localparam int SDRAM_DW = 16;

// Client address widths
localparam int CHAR_AW  = 14;       // 16-bit words
localparam int MAIN_AW  = 18;       // Bytes

// Word offsets of each region inside the SDRAM
localparam logic [SDRAM_AW-1:0] CHAR_OFFSET = 22'h00_4000;
localparam logic [SDRAM_AW-1:0] MAIN_OFFSET = 22'h00_0000;

// Character graphics payload
typedef logic [15:0] char_data_t;

// Main CPU payload, one byte out of a word
typedef logic [7:0]  main_data_t;

// Raw word as read from SDRAM
typedef logic [SDRAM_DW-1:0] sdram_word_t;

// Word address on the SDRAM read port
typedef logic [SDRAM_AW-1:0] sdram_addr_t;

endpackage

// File: rom_slot.sv
`timescale 1ns/100ps
/* One ROM client slot caching the last SDRAM word it fetched
   A hit answers combinationally, a miss raises req until the arbiter fills it
   Serves 16-bit payloads directly and 8-bit payloads by byte select on addr[0] */
module rom_slot #(
    parameter int  AW     = 14,
    parameter type DATA_T = logic [15:0]
) (
    input  logic                 clk,
    input  logic                 rst,
    // Client side
    input  logic                 cs,
    input  logic [AW-1:0]        addr,
    output logic                 ok,
    output DATA_T                data,
    // Arbiter side
    output logic                 req,
    output rom_pkg::sdram_addr_t req_addr,
    input  logic                 fill,
    input  rom_pkg::sdram_word_t fill_data
);

localparam int DW  = $bits(DATA_T);
localparam int WAW = (DW == 8) ? AW - 1 : AW;  // Word address width

logic [WAW-1:0]       word_addr;
logic                 valid;
logic [WAW-1:0]       cache_addr;
rom_pkg::sdram_word_t cache_data;
logic                 hit;
logic                 miss;

generate
    if (DW == 8) begin : g_byte
        // Byte payload, lowest address bit picks the half of the word
        assign word_addr = addr[AW-1:1];
        assign data      = addr[0] ? DATA_T'(cache_data[15:8]) :
                                     DATA_T'(cache_data[7:0]);
    end else begin : g_word
        assign word_addr = addr;
        assign data      = DATA_T'(cache_data);
    end
endgenerate

assign hit  = cs && valid && (word_addr == cache_addr);
assign miss = cs && !hit && !req;   // New request only when none pending
assign ok   = hit;

// Control
always_ff @(posedge clk) begin
    if (rst) begin
        valid <= 1'b0;
        req   <= 1'b0;
    end else begin
        if (fill) begin
            req   <= 1'b0;
            valid <= 1'b1;
        end else if (miss) begin
            req   <= 1'b1;
        end
    end
end

// Payload, request address held until the fill even if addr moves
always_ff @(posedge clk) begin
    if (miss) begin
        req_addr <= rom_pkg::sdram_addr_t'(word_addr);
    end
    if (fill) begin
        cache_addr <= req_addr[WAW-1:0];
        cache_data <= fill_data;
    end
end

endmodule

// File: rom_arbiter.sv
`timescale 1ns/100ps
/* Fixed-priority combiner of the slot misses onto the single SDRAM read port
   Adds each region offset and routes the returned word back to its owner
   One access outstanding at a time, character slot first */
module rom_arbiter (
    input  logic                 clk,
    input  logic                 rst,
    // Slot requests
    input  logic                 char_req,
    input  rom_pkg::sdram_addr_t char_addr,
    input  logic                 main_req,
    input  rom_pkg::sdram_addr_t main_addr,
    // Slot fills
    output logic                 char_fill,
    output logic                 main_fill,
    output rom_pkg::sdram_word_t fill_data,
    // SDRAM read port
    output logic                 sdram_req,
    output rom_pkg::sdram_addr_t sdram_addr,
    input  logic                 sdram_ack,
    input  logic                 data_rdy,
    input  rom_pkg::sdram_word_t data_read
);

typedef enum logic [1:0] {
    IDLE,
    WAIT_ACK,
    WAIT_DATA
} state_t;

state_t state;
logic   owner_main;     // Set when the main slot owns the access
logic   char_pick;
logic   main_pick;
logic   start;

// A slot being filled still shows req for that cycle
assign char_pick = char_req && !char_fill;
assign main_pick = main_req && !main_fill;
assign start     = (state == IDLE) && (char_pick || main_pick);

always_ff @(posedge clk) begin
    if (rst) begin
        state      <= IDLE;
        sdram_req  <= 1'b0;
        char_fill  <= 1'b0;
        main_fill  <= 1'b0;
        owner_main <= 1'b0;
    end else begin
        char_fill <= 1'b0;  // Strobes last one cycle
        main_fill <= 1'b0;
        case (state)
            IDLE: begin
                if (start) begin
                    sdram_req  <= 1'b1;
                    owner_main <= !char_pick;
                    state      <= WAIT_ACK;
                end
            end
            WAIT_ACK: begin
                if (sdram_ack) begin
                    sdram_req <= 1'b0;
                    state     <= WAIT_DATA;
                end
            end
            WAIT_DATA: begin
                if (data_rdy) begin
                    char_fill <= !owner_main;
                    main_fill <= owner_main;
                    state     <= IDLE;
                end
            end
            default: state <= IDLE;
        endcase
    end
end

// Address and returned data
always_ff @(posedge clk) begin
    if (start) begin
        sdram_addr <= char_pick ? char_addr + rom_pkg::CHAR_OFFSET :
                                  main_addr + rom_pkg::MAIN_OFFSET;
    end
    if (state == WAIT_DATA && data_rdy) begin
        fill_data <= data_read;     // Shared by both slots
    end
end

endmodule

// File: rom_hub.sv
`timescale 1ns/100ps
/* ROM slot hub with a character graphics slot and a main CPU slot
   sharing one SDRAM read port through a fixed-priority arbiter */
module rom_hub (
    input  logic                        clk,
    input  logic                        rst,
    // Character graphics client
    input  logic                        char_cs,
    input  logic [rom_pkg::CHAR_AW-1:0] char_addr,
    output logic                        char_ok,
    output rom_pkg::char_data_t         char_data,
    // Main CPU client
    input  logic                        main_cs,
    input  logic [rom_pkg::MAIN_AW-1:0] main_addr,
    output logic                        main_ok,
    output rom_pkg::main_data_t         main_data,
    // SDRAM interface
    output logic                        sdram_req,
    output rom_pkg::sdram_addr_t        sdram_addr,
    input  logic                        sdram_ack,
    input  logic                        data_dst,   // Kept for port compatibility
    input  logic                        data_rdy,
    input  rom_pkg::sdram_word_t        data_read
);

logic                 char_req;
logic                 main_req;
rom_pkg::sdram_addr_t char_req_addr;
rom_pkg::sdram_addr_t main_req_addr;
logic                 char_fill;
logic                 main_fill;
rom_pkg::sdram_word_t fill_data;

rom_slot #(
    .AW     ( rom_pkg::CHAR_AW      ),
    .DATA_T ( rom_pkg::char_data_t  )
) u_char (
    .clk       ( clk           ),
    .rst       ( rst           ),
    .cs        ( char_cs       ),
    .addr      ( char_addr     ),
    .ok        ( char_ok       ),
    .data      ( char_data     ),
    .req       ( char_req      ),
    .req_addr  ( char_req_addr ),
    .fill      ( char_fill     ),
    .fill_data ( fill_data     )
);

rom_slot #(
    .AW     ( rom_pkg::MAIN_AW      ),
    .DATA_T ( rom_pkg::main_data_t  )
) u_main (
    .clk       ( clk           ),
    .rst       ( rst           ),
    .cs        ( main_cs       ),
    .addr      ( main_addr     ),
    .ok        ( main_ok       ),
    .data      ( main_data     ),
    .req       ( main_req      ),
    .req_addr  ( main_req_addr ),
    .fill      ( main_fill     ),
    .fill_data ( fill_data     )
);

rom_arbiter u_arb (
    .clk        ( clk           ),
    .rst        ( rst           ),
    .char_req   ( char_req      ),
    .char_addr  ( char_req_addr ),
    .main_req   ( main_req      ),
    .main_addr  ( main_req_addr ),
    .char_fill  ( char_fill     ),
    .main_fill  ( main_fill     ),
    .fill_data  ( fill_data     ),
    .sdram_req  ( sdram_req     ),
    .sdram_addr ( sdram_addr    ),
    .sdram_ack  ( sdram_ack     ),
    .data_rdy   ( data_rdy      ),
    .data_read  ( data_read     )
);

endmodule

// File: rom_hub_props.sv
`timescale 1ns/100ps
/* Concurrent checks on the SDRAM handshake and the client ok outputs
   Bound into rom_hub by the testbench */
module rom_hub_props (
    input logic                 clk,
    input logic                 rst,
    input logic                 sdram_req,
    input rom_pkg::sdram_addr_t sdram_addr,
    input logic                 sdram_ack,
    input logic                 data_rdy,
    input logic                 char_cs,
    input logic                 char_ok,
    input logic                 main_cs,
    input logic                 main_ok
);

int   assert_errors = 0;    // Read by the testbench for its closing line
logic outstanding;          // Acked, data not yet returned

always_ff @(posedge clk) begin
    if (rst) begin
        outstanding <= 1'b0;
    end else if (sdram_req && sdram_ack) begin
        outstanding <= 1'b1;
    end else if (data_rdy) begin
        outstanding <= 1'b0;
    end
end

a_req_hold: assert property (@(posedge clk) disable iff (rst)
    sdram_req && !sdram_ack |=> sdram_req && $stable(sdram_addr))
    else begin
        assert_errors++;
        $error("sdram_req dropped or sdram_addr changed before sdram_ack");
    end

a_rdy_outstanding: assert property (@(posedge clk) disable iff (rst)
    data_rdy |-> outstanding)
    else begin
        assert_errors++;
        $error("data_rdy without an outstanding SDRAM access");
    end

a_char_ok: assert property (@(posedge clk) !char_cs |-> !char_ok)
    else begin
        assert_errors++;
        $error("char_ok high while char_cs is low");
    end

a_main_ok: assert property (@(posedge clk) !main_cs |-> !main_ok)
    else begin
        assert_errors++;
        $error("main_ok high while main_cs is low");
    end

a_rst_req: assert property (@(posedge clk) rst |=> !sdram_req)
    else begin
        assert_errors++;
        $error("sdram_req high during reset");
    end

endmodule

// File: tb_rom_hub.sv
`timescale 1ns/100ps
/* Testbench for the ROM slot hub with a behavioral SDRAM of random latency
   Accesses and expected data come from rom_trace.txt, one entry per line */
module tb_rom_hub;

logic                        clk = 1'b0;
logic                        rst;
logic                        char_cs;
logic [rom_pkg::CHAR_AW-1:0] char_addr;
logic                        char_ok;
rom_pkg::char_data_t         char_data;
logic                        main_cs;
logic [rom_pkg::MAIN_AW-1:0] main_addr;
logic                        main_ok;
rom_pkg::main_data_t         main_data;
logic                        sdram_req;
rom_pkg::sdram_addr_t        sdram_addr;
logic                        sdram_ack;
logic                        data_dst;
logic                        data_rdy;
rom_pkg::sdram_word_t        data_read;

integer               seed = 32'h38d04d77;
logic [31:0]          trace_mem [0:191];    // Six words per trace entry
rom_pkg::sdram_addr_t addr_log[$];          // Every acked SDRAM address in order
int                   req_count = 0;
int                   checks    = 0;
int                   errors    = 0;
int                   timeouts  = 0;
int                   entry;
bit                   aborted   = 1'b0;

rom_hub u_rom_hub (
    .clk        ( clk        ),
    .rst        ( rst        ),
    .char_cs    ( char_cs    ),
    .char_addr  ( char_addr  ),
    .char_ok    ( char_ok    ),
    .char_data  ( char_data  ),
    .main_cs    ( main_cs    ),
    .main_addr  ( main_addr  ),
    .main_ok    ( main_ok    ),
    .main_data  ( main_data  ),
    .sdram_req  ( sdram_req  ),
    .sdram_addr ( sdram_addr ),
    .sdram_ack  ( sdram_ack  ),
    .data_dst   ( data_dst   ),
    .data_rdy   ( data_rdy   ),
    .data_read  ( data_read  )
);

bind rom_hub rom_hub_props u_props (
    .clk        ( clk        ),
    .rst        ( rst        ),
    .sdram_req  ( sdram_req  ),
    .sdram_addr ( sdram_addr ),
    .sdram_ack  ( sdram_ack  ),
    .data_rdy   ( data_rdy   ),
    .char_cs    ( char_cs    ),
    .char_ok    ( char_ok    ),
    .main_cs    ( main_cs    ),
    .main_ok    ( main_ok    )
);

initial begin
    forever #4 clk = ~clk;
end

// Behavioral SDRAM serving one access at a time
initial begin : sdram_model
    int unsigned          ack_dly;
    int unsigned          rdy_dly;
    rom_pkg::sdram_addr_t acc_addr;
    sdram_ack = 1'b0;
    data_rdy  = 1'b0;
    data_read = '0;
    forever begin
        @(negedge clk);
        if (!rst && sdram_req) begin
            ack_dly = 1 + ($unsigned($random(seed)) % 4);
            repeat (ack_dly - 1) @(negedge clk);
            sdram_ack = 1'b1;
            acc_addr  = sdram_addr;
            addr_log.push_back(sdram_addr);
            req_count++;
            @(negedge clk);
            sdram_ack = 1'b0;
            rdy_dly   = 2 + ($unsigned($random(seed)) % 4);    // Counted from the ack
            repeat (rdy_dly - 1) @(negedge clk);
            data_rdy  = 1'b1;
            data_read = acc_addr[15:0] ^ 16'hA5C3;
            @(negedge clk);
            data_rdy  = 1'b0;
        end
    end
end

task automatic check_char(input rom_pkg::char_data_t actual, input rom_pkg::char_data_t expected);
    checks++;
    if (actual !== expected) begin
        errors++;
        $display("Error: char_data is %h, expected %h at trace entry %0d",
                 actual, expected, entry);
    end
endtask

task automatic check_main(input rom_pkg::main_data_t actual, input rom_pkg::main_data_t expected);
    checks++;
    if (actual !== expected) begin
        errors++;
        $display("Error: main_data is %h, expected %h at trace entry %0d",
                 actual, expected, entry);
    end
endtask

task automatic check_count(input int actual, input int expected);
    checks++;
    if (actual !== expected) begin
        errors++;
        $display("Error: SDRAM request count is %h, expected %h at trace entry %0d",
                 actual, expected, entry);
    end
endtask

task automatic check_flag(input string name, input logic actual, input logic expected);
    checks++;
    if (actual !== expected) begin
        errors++;
        $display("Error: %s is %h, expected %h at trace entry %0d",
                 name, actual, expected, entry);
    end
endtask

task automatic apply_reset();
    rst = 1'b1;
    repeat (4) @(negedge clk);
    rst = 1'b0;
    check_flag("sdram_req", sdram_req, 1'b0);
    check_flag("char_ok", char_ok, 1'b0);
    check_flag("main_ok", main_ok, 1'b0);
endtask

// One trace entry on one or both slots starting at its mode word
task automatic run_access(input int base);
    logic [31:0] mode;
    int          first_log;
    bit          done;
    mode      = trace_mem[base];
    first_log = addr_log.size();
    @(negedge clk);
    char_cs   = mode[0];
    char_addr = trace_mem[base+1][rom_pkg::CHAR_AW-1:0];
    main_cs   = mode[1];
    main_addr = trace_mem[base+2][rom_pkg::MAIN_AW-1:0];
    done      = 1'b0;
    for (int cyc = 0; cyc < 200 && !done; cyc++) begin
        @(negedge clk);
        done = (!mode[0] || char_ok) && (!mode[1] || main_ok);
    end
    if (!done) begin
        timeouts++;
        aborted = 1'b1;
        $display("Timed out after 200 cycles waiting for ok at trace entry %0d", entry);
    end else begin
        if (mode[0])
            check_char(char_data, trace_mem[base+3][15:0]);
        if (mode[1])
            check_main(main_data, trace_mem[base+4][7:0]);
        check_count(req_count, trace_mem[base+5]);
        // On a dual miss the char slot has priority on the SDRAM port
        if (mode == 32'h3 && addr_log.size() > first_log) begin
            if (addr_log[first_log] < rom_pkg::CHAR_OFFSET ||
                addr_log[first_log] >= rom_pkg::CHAR_OFFSET + (1 << rom_pkg::CHAR_AW)) begin
                errors++;
                $display("First SDRAM address %h of trace entry %0d is not in the char region",
                         addr_log[first_log], entry);
            end
        end
    end
    char_cs = 1'b0;
    main_cs = 1'b0;
endtask

initial begin
    rst       = 1'b1;
    char_cs   = 1'b0;
    char_addr = '0;
    main_cs   = 1'b0;
    main_addr = '0;
    data_dst  = 1'b0;
    entry     = 0;
    $readmemh("rom_trace.txt", trace_mem);
    apply_reset();
    while (!aborted && entry < 32 && trace_mem[entry*6] !== 32'hff) begin
        if ($isunknown(trace_mem[entry*6])) begin
            errors++;
            aborted = 1'b1;
            $display("Trace entry %0d is missing or unreadable", entry);
        end else if (trace_mem[entry*6] == 32'h0) begin
            @(negedge clk);
            apply_reset();
            check_count(req_count, trace_mem[entry*6+5]);
        end else begin
            run_access(entry * 6);
        end
        entry++;
    end
    if (entry == 32) begin
        errors++;
        $display("Trace has no end marker within 32 entries");
    end
    $display("Checks %0d, value errors %0d, timeouts %0d, assertion errors %0d",
             checks, errors, timeouts, u_rom_hub.u_props.assert_errors);
    if (errors == 0 && timeouts == 0 && u_rom_hub.u_props.assert_errors == 0) begin
        $display("TEST RESULT: PASS");
    end else begin
        $display("TEST RESULT: FAIL");
    end
    $finish;
end

endmodule

// File: rom_trace.txt
// Columns: mode char_addr main_addr exp_char exp_main exp_count, all hex
// Mode 1 char, 2 main, 3 both, 0 reset only, ff ends the trace
// Char miss, then hit on the same address
1 0123 00000 e4e0 00 1
1 0123 00000 e4e0 00 1
// Main even byte misses, odd byte of the same word hits
2 0000 01000 0000 c3 2
2 0000 01001 0000 ad 2
// Both slots miss together, then both hit
3 2a50 3f00e cf93 c4 4
3 2a50 3f00f cf93 5d 4
// Top of each address range
1 3fff 00000 da3c 00 5
2 0000 3ffff 0000 5a 6
// Main word zero, then char miss beside a main hit
2 0000 00000 0000 c3 7
3 0000 00001 e5c3 a5 8
// Reset drops both caches
0 0000 00000 0000 00 8
1 0000 00000 e5c3 00 9
2 0000 00001 0000 a5 a
// Dual miss after reset, then a char hit
3 0123 01000 e4e0 c3 c
1 0123 00000 e4e0 00 c
// End of trace
ff 0000 00000 0000 00 0

// File: tb.f
rom_pkg.sv
rom_slot.sv
rom_arbiter.sv
rom_hub.sv
rom_hub_props.sv
tb_rom_hub.sv
